//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    // field layout of an R-type word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields;

    // field layout of an I-type word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeFields;

    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;

    // function codes under SPECIAL
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    typedef enum logic [4:0] {
        OP_NOP,
        ALU_ADDIU, ALU_ADDU, ALU_SUBU,
        ALU_AND, ALU_ANDI, ALU_OR, ALU_ORI, ALU_XOR, ALU_XORI,
        ALU_SLL, ALU_SLLV, ALU_SRL, ALU_SRLV, ALU_SRA, ALU_SRAV,
        ALU_SLT, ALU_SLTI, ALU_SLTU, ALU_SLTIU,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
        ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO
    } aluOp;

    typedef struct packed {
        logic        valid;
        aluOp        op;
        logic [4:0]  dest;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        // already extended to 32 bits
        logic [31:0] imm;
        logic [4:0]  sa;
    } decodedInstr;

    typedef struct packed {
        logic        hiEn;
        logic        loEn;
        logic [31:0] hi;
        logic [31:0] lo;
    } hiLoWrite;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } hiLoState;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        logic [4:0]  dest;
        logic [31:0] data;
    } wbResult;

endpackage

`default_nettype wire

//--- verilog/hiLoRegs.sv
`timescale 1ns/1ns
`default_nettype none

module hiLoRegs (
    input  logic              clk,
    input  logic              rst,
    input  mipsPkg::hiLoWrite wr,
    output mipsPkg::hiLoState state
);

    logic [31:0] hiReg;
    logic [31:0] loReg;

    // separate enables so mthi and mtlo leave the other half alone
    always_ff @(posedge clk) begin
        if (rst) begin
            hiReg <= 32'd0;
        end else if (wr.hiEn) begin
            hiReg <= wr.hi;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loReg <= 32'd0;
        end else if (wr.loEn) begin
            loReg <= wr.lo;
        end
    end

    // read straight from the flops
    assign state.hi = hiReg;
    assign state.lo = loReg;

endmodule

`default_nettype wire

//--- verilog/mipsDecode.sv
`timescale 1ns/1ns
`default_nettype none

module mipsDecode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  mipsPkg::instrWord    instr,
    input  logic [31:0]          rsData,
    input  logic [31:0]          rtData,
    output mipsPkg::decodedInstr dec
);

    mipsPkg::aluOp op;
    logic          zeroExt;
    logic [4:0]    dest;
    logic [31:0]   immExt;

    // opcode first, function code only under SPECIAL
    always_comb begin
        op = mipsPkg::OP_NOP;
        case (instr.iType.opcode)
            mipsPkg::OP_SPECIAL: begin
                case (instr.rType.funct)
                    mipsPkg::FN_SLL:   op = mipsPkg::ALU_SLL;
                    mipsPkg::FN_SRL:   op = mipsPkg::ALU_SRL;
                    mipsPkg::FN_SRA:   op = mipsPkg::ALU_SRA;
                    mipsPkg::FN_SLLV:  op = mipsPkg::ALU_SLLV;
                    mipsPkg::FN_SRLV:  op = mipsPkg::ALU_SRLV;
                    mipsPkg::FN_SRAV:  op = mipsPkg::ALU_SRAV;
                    mipsPkg::FN_MFHI:  op = mipsPkg::ALU_MFHI;
                    mipsPkg::FN_MTHI:  op = mipsPkg::ALU_MTHI;
                    mipsPkg::FN_MFLO:  op = mipsPkg::ALU_MFLO;
                    mipsPkg::FN_MTLO:  op = mipsPkg::ALU_MTLO;
                    mipsPkg::FN_MULT:  op = mipsPkg::ALU_MULT;
                    mipsPkg::FN_MULTU: op = mipsPkg::ALU_MULTU;
                    mipsPkg::FN_DIV:   op = mipsPkg::ALU_DIV;
                    mipsPkg::FN_DIVU:  op = mipsPkg::ALU_DIVU;
                    mipsPkg::FN_ADDU:  op = mipsPkg::ALU_ADDU;
                    mipsPkg::FN_SUBU:  op = mipsPkg::ALU_SUBU;
                    mipsPkg::FN_AND:   op = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:    op = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:   op = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT:   op = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLTU:  op = mipsPkg::ALU_SLTU;
                    default:           op = mipsPkg::OP_NOP;
                endcase
            end
            mipsPkg::OP_ADDIU: op = mipsPkg::ALU_ADDIU;
            mipsPkg::OP_SLTI:  op = mipsPkg::ALU_SLTI;
            mipsPkg::OP_SLTIU: op = mipsPkg::ALU_SLTIU;
            mipsPkg::OP_ANDI:  op = mipsPkg::ALU_ANDI;
            mipsPkg::OP_ORI:   op = mipsPkg::ALU_ORI;
            mipsPkg::OP_XORI:  op = mipsPkg::ALU_XORI;
            default:           op = mipsPkg::OP_NOP;
        endcase
    end

    // logical immediates are zero extended, the rest sign extended
    assign zeroExt = (op == mipsPkg::ALU_ANDI) || (op == mipsPkg::ALU_ORI) ||
                     (op == mipsPkg::ALU_XORI);
    assign immExt  = zeroExt ? {16'h0000, instr.iType.imm} :
                               {{16{instr.iType.imm[15]}}, instr.iType.imm};

    // rd for R-type, rt otherwise
    assign dest = (instr.iType.opcode == mipsPkg::OP_SPECIAL) ? instr.rType.rd :
                                                                instr.iType.rt;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instrValid;
        end
        // payload only follows a strobe
        if (instrValid) begin
            dec.op    <= op;
            dec.dest  <= dest;
            dec.rsVal <= rsData;
            dec.rtVal <= rtData;
            dec.imm   <= immExt;
            dec.sa    <= instr.rType.shamt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mipsAlu.sv
`timescale 1ns/1ns
`default_nettype none

module mipsAlu (
    input  logic                 clk,
    input  logic                 rst,
    input  mipsPkg::decodedInstr dec,
    input  mipsPkg::hiLoState    hiLo,
    output mipsPkg::hiLoWrite    hiLoWr,
    output mipsPkg::wbResult     wb
);

    logic [31:0]        result;
    logic               regWrite;
    logic               hiEn;
    logic               loEn;
    logic [31:0]        hiNext;
    logic [31:0]        loNext;
    logic signed [63:0] prodS;
    logic [63:0]        prodU;
    logic [31:0]        quotU;
    logic [31:0]        remU;
    logic [31:0]        quotS;
    logic [31:0]        remS;

    // full 64-bit products
    assign prodS = $signed(dec.rsVal) * $signed(dec.rtVal);
    assign prodU = dec.rsVal * dec.rtVal;

    // unsigned divide, zero divisor handled by hand
    always_comb begin
        if (dec.rtVal == 32'd0) begin
            quotU = '1;
            remU  = dec.rsVal;
        end else begin
            quotU = dec.rsVal / dec.rtVal;
            remU  = dec.rsVal % dec.rtVal;
        end
    end

    // signed divide truncates toward zero, remainder follows the dividend
    always_comb begin
        if (dec.rtVal == 32'd0) begin
            quotS = '1;
            remS  = dec.rsVal;
        end else if (dec.rsVal == 32'h8000_0000 && dec.rtVal == 32'hffff_ffff) begin
            // overflow case
            quotS = 32'h8000_0000;
            remS  = 32'd0;
        end else begin
            quotS = $signed(dec.rsVal) / $signed(dec.rtVal);
            remS  = $signed(dec.rsVal) % $signed(dec.rtVal);
        end
    end

    always_comb begin
        result   = 32'd0;
        regWrite = 1'b1;
        hiEn     = 1'b0;
        loEn     = 1'b0;
        hiNext   = 32'd0;
        loNext   = 32'd0;
        case (dec.op)
            mipsPkg::ALU_ADDIU: result = dec.rsVal + dec.imm;
            mipsPkg::ALU_ADDU:  result = dec.rsVal + dec.rtVal;
            mipsPkg::ALU_SUBU:  result = dec.rsVal - dec.rtVal;
            mipsPkg::ALU_AND:   result = dec.rsVal & dec.rtVal;
            mipsPkg::ALU_ANDI:  result = dec.rsVal & dec.imm;
            mipsPkg::ALU_OR:    result = dec.rsVal | dec.rtVal;
            mipsPkg::ALU_ORI:   result = dec.rsVal | dec.imm;
            mipsPkg::ALU_XOR:   result = dec.rsVal ^ dec.rtVal;
            mipsPkg::ALU_XORI:  result = dec.rsVal ^ dec.imm;
            mipsPkg::ALU_SLL:   result = dec.rtVal << dec.sa;
            mipsPkg::ALU_SLLV:  result = dec.rtVal << dec.rsVal[4:0];
            mipsPkg::ALU_SRL:   result = dec.rtVal >> dec.sa;
            mipsPkg::ALU_SRLV:  result = dec.rtVal >> dec.rsVal[4:0];
            mipsPkg::ALU_SRA:   result = $signed(dec.rtVal) >>> dec.sa;
            mipsPkg::ALU_SRAV:  result = $signed(dec.rtVal) >>> dec.rsVal[4:0];
            mipsPkg::ALU_SLT:   result = {31'd0, $signed(dec.rsVal) < $signed(dec.rtVal)};
            mipsPkg::ALU_SLTI:  result = {31'd0, $signed(dec.rsVal) < $signed(dec.imm)};
            mipsPkg::ALU_SLTU:  result = {31'd0, dec.rsVal < dec.rtVal};
            // sign-extended immediate, compared unsigned
            mipsPkg::ALU_SLTIU: result = {31'd0, dec.rsVal < dec.imm};
            mipsPkg::ALU_MFHI:  result = hiLo.hi;
            mipsPkg::ALU_MFLO:  result = hiLo.lo;
            mipsPkg::ALU_MULT: begin
                regWrite = 1'b0;
                hiEn     = 1'b1;
                loEn     = 1'b1;
                hiNext   = prodS[63:32];
                loNext   = prodS[31:0];
            end
            mipsPkg::ALU_MULTU: begin
                regWrite = 1'b0;
                hiEn     = 1'b1;
                loEn     = 1'b1;
                hiNext   = prodU[63:32];
                loNext   = prodU[31:0];
            end
            mipsPkg::ALU_DIV: begin
                regWrite = 1'b0;
                hiEn     = 1'b1;
                loEn     = 1'b1;
                hiNext   = remS;
                loNext   = quotS;
            end
            mipsPkg::ALU_DIVU: begin
                regWrite = 1'b0;
                hiEn     = 1'b1;
                loEn     = 1'b1;
                hiNext   = remU;
                loNext   = quotU;
            end
            mipsPkg::ALU_MTHI: begin
                regWrite = 1'b0;
                hiEn     = 1'b1;
                hiNext   = dec.rsVal;
            end
            mipsPkg::ALU_MTLO: begin
                regWrite = 1'b0;
                loEn     = 1'b1;
                loNext   = dec.rsVal;
            end
            default: regWrite = 1'b0;
        endcase
    end

    // HI/LO land on the same edge as the writeback beat
    assign hiLoWr.hiEn = dec.valid && hiEn;
    assign hiLoWr.loEn = dec.valid && loEn;
    assign hiLoWr.hi   = hiNext;
    assign hiLoWr.lo   = loNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid    <= 1'b0;
            wb.regWrite <= 1'b0;
        end else begin
            wb.valid    <= dec.valid;
            wb.regWrite <= dec.valid && regWrite;
        end
        if (dec.valid) begin
            wb.dest <= dec.dest;
            wb.data <= result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mipsExec.sv
`timescale 1ns/1ns
`default_nettype none

module mipsExec (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,
    input  mipsPkg::instrWord instr,
    input  logic [31:0]       rsData,
    input  logic [31:0]       rtData,
    output mipsPkg::wbResult  wb
);

    mipsPkg::decodedInstr dec;
    mipsPkg::hiLoWrite    hiLoWr;
    mipsPkg::hiLoState    hiLo;

    // stage one, decode and operand capture
    mipsDecode mipsDecode_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .rsData     (rsData),
        .rtData     (rtData),
        .dec        (dec)
    );

    // stage two, execute and writeback register
    mipsAlu mipsAlu_i (
        .clk    (clk),
        .rst    (rst),
        .dec    (dec),
        .hiLo   (hiLo),
        .hiLoWr (hiLoWr),
        .wb     (wb)
    );

    // special registers for mult/div results
    hiLoRegs hiLoRegs_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (hiLoWr),
        .state (hiLo)
    );

endmodule

`default_nettype wire

//--- testbench/mipsModel.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// model copies of the special registers
logic [31:0] modelHi = 32'd0;
logic [31:0] modelLo = 32'd0;
logic        lastMulDiv = 1'b0;

localparam logic [5:0] SPECIAL_FUNCTS [21] = '{
    mipsPkg::FN_SLL, mipsPkg::FN_SRL, mipsPkg::FN_SRA, mipsPkg::FN_SLLV,
    mipsPkg::FN_SRLV, mipsPkg::FN_SRAV, mipsPkg::FN_MFHI, mipsPkg::FN_MTHI,
    mipsPkg::FN_MFLO, mipsPkg::FN_MTLO, mipsPkg::FN_MULT, mipsPkg::FN_MULTU,
    mipsPkg::FN_DIV, mipsPkg::FN_DIVU, mipsPkg::FN_ADDU, mipsPkg::FN_SUBU,
    mipsPkg::FN_AND, mipsPkg::FN_OR, mipsPkg::FN_XOR, mipsPkg::FN_SLT,
    mipsPkg::FN_SLTU
};

localparam logic [5:0] IMM_OPCODES [6] = '{
    mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU,
    mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI
};

// corner values show up far more often than in a flat draw
function automatic logic [31:0] randOperand();
    case ($urandom % 8)
        0: return 32'd0;
        1: return 32'hffff_ffff;
        2: return 32'h8000_0000;
        3, 4: return $urandom % 32;
        default: return $urandom;
    endcase
endfunction

function automatic logic isMulDiv(mipsPkg::instrWord w);
    return (w.rType.opcode == mipsPkg::OP_SPECIAL) &&
           (w.rType.funct inside {mipsPkg::FN_MULT, mipsPkg::FN_MULTU,
                                  mipsPkg::FN_DIV, mipsPkg::FN_DIVU});
endfunction

task automatic pickStimulus(output mipsPkg::instrWord w, output logic [31:0] rsV,
                            output logic [31:0] rtV);
    int unsigned sel;
    w = $urandom;
    sel = $urandom % 16;
    if (lastMulDiv && ($urandom % 2 == 0)) begin
        // read back right behind a HI/LO write
        w.rType.opcode = mipsPkg::OP_SPECIAL;
        w.rType.funct  = ($urandom % 2 == 0) ? mipsPkg::FN_MFHI : mipsPkg::FN_MFLO;
    end else if (sel < 10) begin
        w.rType.opcode = mipsPkg::OP_SPECIAL;
        w.rType.funct  = SPECIAL_FUNCTS[$urandom % 21];
    end else if (sel < 15) begin
        w.iType.opcode = IMM_OPCODES[$urandom % 6];
    end
    // sel 15 keeps the raw word, nearly always an illegal encoding
    rsV = randOperand();
    rtV = randOperand();
    if (w.rType.opcode == mipsPkg::OP_SPECIAL && w.rType.funct == mipsPkg::FN_DIV &&
        ($urandom % 4 == 0)) begin
        // signed overflow case
        rsV = 32'h8000_0000;
        rtV = 32'hffff_ffff;
    end
    lastMulDiv = isMulDiv(w);
endtask

function automatic logic lessSigned(logic [31:0] a, logic [31:0] b);
    // differing signs decide on their own
    if (a[31] != b[31]) begin
        return a[31];
    end
    return a < b;
endfunction

function automatic logic [31:0] shiftArith(logic [31:0] v, logic [4:0] amt);
    logic [63:0] wide;
    wide = {{32{v[31]}}, v} >> amt;
    return wide[31:0];
endfunction

// divide magnitudes, then fix signs
task automatic divideSigned(input logic [31:0] a, input logic [31:0] b,
                            output logic [31:0] q, output logic [31:0] r);
    logic [31:0] magA;
    logic [31:0] magB;
    if (b == 32'd0) begin
        q = 32'hffff_ffff;
        r = a;
    end else begin
        magA = a[31] ? -a : a;
        magB = b[31] ? -b : b;
        q = (a[31] ^ b[31]) ? -(magA / magB) : magA / magB;
        r = a[31] ? -(magA % magB) : magA % magB;
    end
endtask

task automatic modelStep(input mipsPkg::instrWord w, input logic [31:0] rs,
                         input logic [31:0] rt, output mipsPkg::wbResult res);
    logic [31:0] sImm;
    logic [31:0] zImm;
    logic [31:0] q;
    logic [31:0] r;
    logic [31:0] data;
    logic        wr;
    sImm = {{16{w.iType.imm[15]}}, w.iType.imm};
    zImm = {16'h0000, w.iType.imm};
    wr   = 1'b1;
    data = 32'd0;
    if (w.iType.opcode == mipsPkg::OP_SPECIAL) begin
        case (w.rType.funct)
            mipsPkg::FN_SLL:  data = rt << w.rType.shamt;
            mipsPkg::FN_SRL:  data = rt >> w.rType.shamt;
            mipsPkg::FN_SRA:  data = shiftArith(rt, w.rType.shamt);
            mipsPkg::FN_SLLV: data = rt << rs[4:0];
            mipsPkg::FN_SRLV: data = rt >> rs[4:0];
            mipsPkg::FN_SRAV: data = shiftArith(rt, rs[4:0]);
            mipsPkg::FN_ADDU: data = rs + rt;
            mipsPkg::FN_SUBU: data = rs - rt;
            mipsPkg::FN_AND:  data = rs & rt;
            mipsPkg::FN_OR:   data = rs | rt;
            mipsPkg::FN_XOR:  data = rs ^ rt;
            mipsPkg::FN_SLT:  data = {31'd0, lessSigned(rs, rt)};
            mipsPkg::FN_SLTU: data = {31'd0, rs < rt};
            mipsPkg::FN_MFHI: data = modelHi;
            mipsPkg::FN_MFLO: data = modelLo;
            mipsPkg::FN_MTHI: begin
                wr = 1'b0;
                modelHi = rs;
            end
            mipsPkg::FN_MTLO: begin
                wr = 1'b0;
                modelLo = rs;
            end
            mipsPkg::FN_MULT: begin
                wr = 1'b0;
                {modelHi, modelLo} = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};
            end
            mipsPkg::FN_MULTU: begin
                wr = 1'b0;
                {modelHi, modelLo} = {32'd0, rs} * {32'd0, rt};
            end
            mipsPkg::FN_DIV: begin
                wr = 1'b0;
                divideSigned(rs, rt, q, r);
                modelLo = q;
                modelHi = r;
            end
            mipsPkg::FN_DIVU: begin
                wr = 1'b0;
                modelLo = (rt == 32'd0) ? 32'hffff_ffff : rs / rt;
                modelHi = (rt == 32'd0) ? rs : rs % rt;
            end
            default: wr = 1'b0;
        endcase
    end else begin
        case (w.iType.opcode)
            mipsPkg::OP_ADDIU: data = rs + sImm;
            mipsPkg::OP_SLTI:  data = {31'd0, lessSigned(rs, sImm)};
            mipsPkg::OP_SLTIU: data = {31'd0, rs < sImm};
            mipsPkg::OP_ANDI:  data = rs & zImm;
            mipsPkg::OP_ORI:   data = rs | zImm;
            mipsPkg::OP_XORI:  data = rs ^ zImm;
            default:           wr = 1'b0;
        endcase
    end
    res.valid    = 1'b1;
    res.regWrite = wr;
    res.dest     = (w.iType.opcode == mipsPkg::OP_SPECIAL) ? w.rType.rd : w.iType.rt;
    res.data     = data;
endtask

`endif

//--- testbench/mipsExecTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsExecTb;

    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 4;
    localparam int TIMEOUT_NS   = (NUM_INSTR * 2 + RESET_CYCLES + 50) * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              rst;
    logic              instrValid;
    mipsPkg::instrWord instr;
    logic [31:0]       rsData;
    logic [31:0]       rtData;
    mipsPkg::wbResult  wb;

    mipsPkg::wbResult expQ[$];
    int unsigned      dueQ[$];
    int unsigned      cycle = 0;
    int               valueErrors = 0;
    int               otherErrors = 0;

    `include "mipsModel.svh"

    mipsExec mipsExec_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .rsData     (rsData),
        .rtData     (rtData),
        .wb         (wb)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check(input string what, input logic [63:0] expV, input logic [63:0] actV);
        if (actV !== expV) begin
            valueErrors++;
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, what, expV, actV);
        end
    endtask

    // each beat is compared on the falling edge
    always @(negedge clk) begin : checkBeat
        mipsPkg::wbResult expV;
        int unsigned      due;
        if (rst) begin
            if (wb.valid !== 1'b0) begin
                otherErrors++;
                $display("wb.valid was high during reset at %0t ns", $time);
            end
        end else if (wb.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("wb.valid at %0t ns with no instruction outstanding", $time);
            end else begin
                expV = expQ.pop_front();
                due  = dueQ.pop_front();
                check("beat cycle", 64'(due), 64'(cycle));
                check("regWrite", 64'(expV.regWrite), 64'(wb.regWrite));
                check("dest", 64'(expV.dest), 64'(wb.dest));
                check("data", 64'(expV.data), 64'(wb.data));
            end
        end
    end

    initial begin : stimulus
        mipsPkg::instrWord w;
        logic [31:0]       rsV;
        logic [31:0]       rtV;
        mipsPkg::wbResult  expV;
        int                issued;
        void'($urandom(32'h575cc1a0));
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        rsData     = 32'd0;
        rtData     = 32'd0;
        issued     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        while (issued < NUM_INSTR) begin
            @(posedge clk);
            if ($urandom % 4 != 0) begin
                if (issued < 2) begin
                    // first reads of HI and LO straight out of reset
                    w              = '0;
                    w.rType.rd     = 5'($urandom);
                    w.rType.funct  = (issued == 0) ? mipsPkg::FN_MFHI : mipsPkg::FN_MFLO;
                    rsV            = $urandom;
                    rtV            = $urandom;
                end else begin
                    pickStimulus(w, rsV, rtV);
                end
                modelStep(w, rsV, rtV, expV);
                expQ.push_back(expV);
                // cycle still holds the count before this edge
                dueQ.push_back(cycle + 3);
                instrValid <= 1'b1;
                instr      <= w;
                rsData     <= rsV;
                rtData     <= rtV;
                issued++;
            end else begin
                // junk payload with the strobe low
                instrValid <= 1'b0;
                instr      <= $urandom;
                rsData     <= $urandom;
                rtData     <= $urandom;
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            otherErrors += expQ.size();
            $display("%0d instructions never produced a writeback beat", expQ.size());
        end
        $display("%0d instructions, %0d value mismatches, %0d other errors",
                 issued, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired at %0t ns before the test finished", $time);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mipsExec.f
+incdir+testbench
verilog/mipsPkg.sv
verilog/hiLoRegs.sv
verilog/mipsDecode.sv
verilog/mipsAlu.sv
verilog/mipsExec.sv
testbench/mipsExecTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mipsExec testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f mipsExec.f --top-module mipsExecTb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
